/* files.f */
logic/kitchen_pkg.sv
logic/display_pkg.sv
logic/player_action_if.sv
logic/button_debounce.sv
logic/player_motion.sv
logic/kitchen_grid.sv
logic/seg_display.sv
logic/kitchen_top.sv
test/kitchen_checker.sv
test/kitchen_tb.sv

/* logic/button_debounce.sv */
`timescale 1ns/1ps

module button_debounce #(
   parameter int debounce_cycles = 1000000
) (
   input  logic clock_in,
   input  logic reset_in,
   input  logic noisy,
   output logic clean,
   output logic rise,
   output logic fall
);

   typedef logic [$clog2(debounce_cycles + 1) - 1:0] count_t;

   // cycles since the raw input last changed
   count_t count;
   // last raw sample
   logic   sample;

   always_ff @(posedge clock_in) begin
      if (reset_in) begin
         // start settled on whatever the pin shows
         sample <= noisy;
         clean  <= noisy;
         count  <= '0;
         rise   <= 1'b0;
         fall   <= 1'b0;
      end else begin
         rise <= 1'b0;
         fall <= 1'b0;
         if (noisy != sample) begin
            // bounce, restart the stability window
            sample <= noisy;
            count  <= '0;
         end else if (count != count_t'(debounce_cycles)) begin
            count <= count + 1'b1;
         end else if (clean != sample) begin
            // stable long enough, take it and flag the edge
            clean <= sample;
            rise  <= sample;
            fall  <= ~sample;
         end
      end
   end

endmodule

/* logic/display_pkg.sv */
package display_pkg;

   ////////////////////
   // seven-segment
   ////////////////////

   // one hex nibble of the score
   typedef logic [3:0] digit_t;

   // a in bit 0 through g in bit 6, low lights the segment
   typedef logic [6:0] segments_t;

   // low selects the digit
   typedef logic [3:0] anodes_t;

   // which of the four digits is lit
   typedef logic [1:0] digit_sel_t;

   // scan timing
   typedef logic [7:0] scan_count_t;
   localparam scan_count_t SCAN_CYCLES = 8'd4;

endpackage

/* logic/kitchen_grid.sv */
`timescale 1ns/1ps

module kitchen_grid import kitchen_pkg::*; (
   input  logic          clock_in,
   input  logic          reset_in,
   player_action_if.sink action,
   output item_t         held_item,
   output score_t        score
);

   // item and chop progress for every tile
   item_t grid_item [GRID_ROWS][GRID_COLS];
   chop_t grid_chop [GRID_ROWS][GRID_COLS];

   ////////////////////
   // faced tile
   ////////////////////

   item_t tile_item;
   chop_t tile_chop;
   logic  at_supply;
   logic  at_window;
   logic  on_floor;

   assign tile_item = grid_item[action.target_y][action.target_x];
   assign tile_chop = grid_chop[action.target_y][action.target_x];

   assign at_supply = action.target_valid &&
                      (action.target_x == SUPPLY_X) && (action.target_y == SUPPLY_Y);
   assign at_window = action.target_valid &&
                      (action.target_x == WINDOW_X) && (action.target_y == WINDOW_Y);
   // anything else in range is plain floor
   assign on_floor  = action.target_valid && !at_supply && !at_window;

   ////////////////////
   // rules
   ////////////////////

   always_ff @(posedge clock_in) begin
      if (reset_in) begin
         for (int row = 0; row < GRID_ROWS; row++) begin
            for (int col = 0; col < GRID_COLS; col++) begin
               grid_item[row][col] <= ITEM_NONE;
               grid_chop[row][col] <= '0;
            end
         end
         held_item <= ITEM_NONE;
         score     <= '0;
      end else if (action.pick && held_item == ITEM_NONE) begin
         // supply never runs out
         if (at_supply) begin
            held_item <= ITEM_RAW;
         end else if (on_floor && tile_item != ITEM_NONE) begin
            held_item                                   <= tile_item;
            grid_item[action.target_y][action.target_x] <= ITEM_NONE;
            grid_chop[action.target_y][action.target_x] <= '0;
         end
      end else if (action.drop && held_item != ITEM_NONE) begin
         // window only takes finished onions, raw stays in hand
         if (at_window && held_item == ITEM_CHOPPED) begin
            score     <= score + 16'd1;
            held_item <= ITEM_NONE;
         end else if (on_floor && tile_item == ITEM_NONE) begin
            grid_item[action.target_y][action.target_x] <= held_item;
            grid_chop[action.target_y][action.target_x] <= '0;
            held_item                                   <= ITEM_NONE;
         end
      end else if (action.chop && on_floor && tile_item == ITEM_RAW) begin
         // last press finishes the onion
         if (tile_chop == CHOP_PRESSES - 2'd1) begin
            grid_item[action.target_y][action.target_x] <= ITEM_CHOPPED;
            grid_chop[action.target_y][action.target_x] <= '0;
         end else begin
            grid_chop[action.target_y][action.target_x] <= tile_chop + 2'd1;
         end
      end
   end

endmodule

/* logic/kitchen_pkg.sv */
package kitchen_pkg;

   ////////////////////
   // grid coordinates
   ////////////////////

   // column 0..12, row 0..7, row 0 on top
   typedef logic [3:0] tile_x_t;
   typedef logic [2:0] tile_y_t;

   localparam int GRID_COLS = 13;
   localparam int GRID_ROWS = 8;

   // last legal column and row
   localparam tile_x_t LAST_X = tile_x_t'(GRID_COLS - 1);
   localparam tile_y_t LAST_Y = tile_y_t'(GRID_ROWS - 1);

   // fixed stations
   localparam tile_x_t SUPPLY_X = 4'd0;
   localparam tile_y_t SUPPLY_Y = 3'd0;
   localparam tile_x_t WINDOW_X = 4'd12;
   localparam tile_y_t WINDOW_Y = 3'd0;

   ////////////////////
   // items and facing
   ////////////////////

   typedef logic [1:0] item_t;
   localparam item_t ITEM_NONE    = 2'd0;
   localparam item_t ITEM_RAW     = 2'd1;
   localparam item_t ITEM_CHOPPED = 2'd2;

   typedef logic [1:0] dir_t;
   localparam dir_t DIR_UP    = 2'd0;
   localparam dir_t DIR_RIGHT = 2'd1;
   localparam dir_t DIR_DOWN  = 2'd2;
   localparam dir_t DIR_LEFT  = 2'd3;

   // reset spot, next to the supply and facing it
   localparam tile_x_t START_X   = 4'd1;
   localparam tile_y_t START_Y   = 3'd0;
   localparam dir_t    START_DIR = DIR_LEFT;

   // chop progress per tile, and the count that finishes an onion
   typedef logic [1:0] chop_t;
   localparam chop_t CHOP_PRESSES = 2'd3;

   typedef logic [15:0] score_t;

endpackage

/* logic/kitchen_top.sv */
`timescale 1ns/1ps

module kitchen_top import kitchen_pkg::*, display_pkg::*; #(
   parameter int debounce_cycles = 1000000
) (
   input  logic      clock_in,
   input  logic      reset_in,
   input  logic      btn_left,
   input  logic      btn_right,
   input  logic      btn_up,
   input  logic      btn_down,
   input  logic      btn_chop,
   input  logic      carry_switch,
   output tile_x_t   player_x,
   output tile_y_t   player_y,
   output dir_t      facing,
   output item_t     held_item,
   output score_t    score,
   output segments_t seg_cathodes,
   output anodes_t   seg_anodes
);

   ////////////////////
   // debounced edges
   ////////////////////

   logic left_rise, right_rise, up_rise, down_rise, chop_rise;
   logic carry_rise, carry_fall;

   // buttons only need the press edge
   button_debounce #(.debounce_cycles(debounce_cycles)) u_db_left (.clock_in, .reset_in,
      .noisy(btn_left), .clean(), .rise(left_rise), .fall());
   button_debounce #(.debounce_cycles(debounce_cycles)) u_db_right (.clock_in, .reset_in,
      .noisy(btn_right), .clean(), .rise(right_rise), .fall());
   button_debounce #(.debounce_cycles(debounce_cycles)) u_db_up (.clock_in, .reset_in,
      .noisy(btn_up), .clean(), .rise(up_rise), .fall());
   button_debounce #(.debounce_cycles(debounce_cycles)) u_db_down (.clock_in, .reset_in,
      .noisy(btn_down), .clean(), .rise(down_rise), .fall());
   button_debounce #(.debounce_cycles(debounce_cycles)) u_db_chop (.clock_in, .reset_in,
      .noisy(btn_chop), .clean(), .rise(chop_rise), .fall());
   // carry switch picks up on rise, puts down on fall
   button_debounce #(.debounce_cycles(debounce_cycles)) u_db_carry (.clock_in, .reset_in,
      .noisy(carry_switch), .clean(), .rise(carry_rise), .fall(carry_fall));

   ////////////////////
   // game core
   ////////////////////

   player_action_if u_action ();

   player_motion u_player_motion (.clock_in, .reset_in,
      .move_left(left_rise), .move_right(right_rise), .move_up(up_rise),
      .move_down(down_rise), .chop_press(chop_rise), .carry_rise, .carry_fall,
      .action(u_action.source), .player_x, .player_y, .facing);

   kitchen_grid u_kitchen_grid (.clock_in, .reset_in, .action(u_action.sink),
      .held_item, .score);

   // score in hex on the four digits
   seg_display u_seg_display (.clock_in, .reset_in, .score, .seg_cathodes, .seg_anodes);

endmodule

/* logic/player_action_if.sv */
`timescale 1ns/1ps

interface player_action_if import kitchen_pkg::*; ();

   // tile in front of the player
   tile_x_t target_x;
   tile_y_t target_y;
   // low when the player faces the border
   logic    target_valid;

   // one-cycle action pulses
   logic    chop;
   logic    pick;
   logic    drop;

   // motion side
   modport source (output target_x, target_y, target_valid, chop, pick, drop);

   // grid side, consumes every pulse in the cycle it arrives
   modport sink (input target_x, target_y, target_valid, chop, pick, drop);

endinterface

/* logic/player_motion.sv */
`timescale 1ns/1ps

module player_motion import kitchen_pkg::*; (
   input  logic            clock_in,
   input  logic            reset_in,
   input  logic            move_left,
   input  logic            move_right,
   input  logic            move_up,
   input  logic            move_down,
   input  logic            chop_press,
   input  logic            carry_rise,
   input  logic            carry_fall,
   player_action_if.source action,
   output tile_x_t         player_x,
   output tile_y_t         player_y,
   output dir_t            facing
);

   ////////////////////
   // position and facing
   ////////////////////

   // priority up, right, down, left
   // facing always turns, the step is clamped at the border
   always_ff @(posedge clock_in) begin
      if (reset_in) begin
         player_x <= START_X;
         player_y <= START_Y;
         facing   <= START_DIR;
      end else if (move_up) begin
         facing <= DIR_UP;
         if (player_y != 3'd0) player_y <= player_y - 1'b1;
      end else if (move_right) begin
         facing <= DIR_RIGHT;
         if (player_x != LAST_X) player_x <= player_x + 1'b1;
      end else if (move_down) begin
         facing <= DIR_DOWN;
         if (player_y != LAST_Y) player_y <= player_y + 1'b1;
      end else if (move_left) begin
         facing <= DIR_LEFT;
         if (player_x != 4'd0) player_x <= player_x - 1'b1;
      end
   end

   ////////////////////
   // target tile
   ////////////////////

   // neighbour in the facing direction
   always_comb begin
      action.target_x     = player_x;
      action.target_y     = player_y;
      action.target_valid = 1'b0;
      case (facing)
         DIR_UP: begin
            action.target_y     = player_y - 1'b1;
            action.target_valid = (player_y != 3'd0);
         end
         DIR_RIGHT: begin
            action.target_x     = player_x + 1'b1;
            action.target_valid = (player_x != LAST_X);
         end
         DIR_DOWN: begin
            action.target_y     = player_y + 1'b1;
            action.target_valid = (player_y != LAST_Y);
         end
         default: begin
            action.target_x     = player_x - 1'b1;
            action.target_valid = (player_x != 4'd0);
         end
      endcase
   end

   // action pulses, one cycle behind the debounced edge
   always_ff @(posedge clock_in) begin
      if (reset_in) begin
         action.chop <= 1'b0;
         action.pick <= 1'b0;
         action.drop <= 1'b0;
      end else begin
         action.chop <= chop_press;
         action.pick <= carry_rise;
         action.drop <= carry_fall;
      end
   end

endmodule

/* logic/seg_display.sv */
`timescale 1ns/1ps

module seg_display import kitchen_pkg::*, display_pkg::*; (
   input  logic      clock_in,
   input  logic      reset_in,
   input  score_t    score,
   output segments_t seg_cathodes,
   output anodes_t   seg_anodes
);

   scan_count_t scan_count;
   digit_sel_t  digit_sel;
   digit_t      digit;

   // hold each digit SCAN_CYCLES clocks, digit 0 first
   always_ff @(posedge clock_in) begin
      if (reset_in) begin
         scan_count <= '0;
         digit_sel  <= '0;
      end else if (scan_count == SCAN_CYCLES - 8'd1) begin
         scan_count <= '0;
         digit_sel  <= digit_sel + 1'b1;
      end else begin
         scan_count <= scan_count + 8'd1;
      end
   end

   // nibble k on anode k
   assign digit      = score[digit_sel * 4 +: 4];
   assign seg_anodes = ~(anodes_t'(1) << digit_sel);

   // hex decode, patterns written active high then inverted
   always_comb begin
      case (digit)
         4'h0: seg_cathodes = ~7'h3F;
         4'h1: seg_cathodes = ~7'h06;
         4'h2: seg_cathodes = ~7'h5B;
         4'h3: seg_cathodes = ~7'h4F;
         4'h4: seg_cathodes = ~7'h66;
         4'h5: seg_cathodes = ~7'h6D;
         4'h6: seg_cathodes = ~7'h7D;
         4'h7: seg_cathodes = ~7'h07;
         4'h8: seg_cathodes = ~7'h7F;
         4'h9: seg_cathodes = ~7'h6F;
         4'hA: seg_cathodes = ~7'h77;
         4'hB: seg_cathodes = ~7'h7C;
         4'hC: seg_cathodes = ~7'h39;
         4'hD: seg_cathodes = ~7'h5E;
         4'hE: seg_cathodes = ~7'h79;
         default: seg_cathodes = ~7'h71;
      endcase
   end

endmodule

/* run.sh */
#!/bin/sh
# build and run the kitchen testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f files.f \
      --top-module kitchen_tb --Mdir obj_dir -o kitchen_sim; then
   echo "verilator build failed"
   exit 1
fi

sim_output=$(./obj_dir/kitchen_sim)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_output" | grep -q "Regression passed"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* test/kitchen_checker.sv */
`timescale 1ns/1ps

module kitchen_checker import kitchen_pkg::*, display_pkg::*; (
   input logic    clock_in,
   input logic    reset_in,
   input tile_x_t player_x,
   input tile_y_t player_y,
   input anodes_t seg_anodes,
   input score_t  score
);

   ////////////////////
   // position range
   ////////////////////

   x_in_grid: assert property (@(posedge clock_in) disable iff (reset_in)
      player_x <= LAST_X)
      else $error("player_x %0d beyond the last column", player_x);

   y_in_grid: assert property (@(posedge clock_in) disable iff (reset_in)
      player_y <= LAST_Y)
      else $error("player_y %0d beyond the last row", player_y);

   // one digit lit at a time
   anode_one_cold: assert property (@(posedge clock_in) disable iff (reset_in)
      $onehot(~seg_anodes))
      else $error("seg_anodes %b not one-cold", seg_anodes);

   // score only counts up
   score_no_drop: assert property (@(posedge clock_in) disable iff (reset_in)
      score >= $past(score))
      else $error("score dropped to %0d", score);

endmodule

/* test/kitchen_tb.sv */
`timescale 1ns/1ps

module kitchen_tb import kitchen_pkg::*, display_pkg::*; ();

   ////////////////////
   // setup
   ////////////////////

   localparam int DEBOUNCE      = 6;
   // stable window plus one edge to take it, then motion and grid stages
   localparam int SETTLE_CYCLES = DEBOUNCE + 4;
   localparam int BOUNCE_CYCLES = 4;
   localparam int WAIT_LIMIT    = 64;
   localparam int NUM_ROWS      = 38;

   // first four share the dir_t codes
   typedef enum logic [2:0] {K_UP, K_RIGHT, K_DOWN, K_LEFT, K_CHOP, K_CARRY} key_t;

   typedef struct packed {
      key_t       key;
      logic       bounce;
      logic [3:0] reps;
   } stim_t;

   // visible outputs and the reference model state
   typedef struct packed {
      tile_x_t x;
      tile_y_t y;
      dir_t    d;
      item_t   h;
      score_t  s;
   } view_t;

   // hex digit patterns with segment a in bit 0 and lit segments high
   localparam logic [6:0] HEX_ON [16] = '{
      7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
      7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

   // key, bounce, number of presses
   localparam stim_t STIM [NUM_ROWS] = '{
      // edges on all four sides and bounced single steps
      '{K_UP, 1'b1, 4'd1}, '{K_LEFT, 1'b0, 4'd2}, '{K_UP, 1'b0, 4'd1},
      '{K_DOWN, 1'b0, 4'd8}, '{K_RIGHT, 1'b0, 4'd13}, '{K_UP, 1'b0, 4'd8},
      '{K_LEFT, 1'b1, 4'd11},
      // supply pick, then two chops leave it raw and three finish it
      '{K_CARRY, 1'b1, 4'd1}, '{K_DOWN, 1'b1, 4'd1}, '{K_CARRY, 1'b0, 4'd1},
      '{K_CHOP, 1'b1, 4'd2}, '{K_CARRY, 1'b0, 4'd1}, '{K_CARRY, 1'b0, 4'd1},
      '{K_CHOP, 1'b0, 4'd3}, '{K_CARRY, 1'b0, 4'd1},
      // first serve
      '{K_UP, 1'b0, 4'd1}, '{K_RIGHT, 1'b0, 4'd10}, '{K_CARRY, 1'b0, 4'd1},
      // raw at the window bounces back
      '{K_LEFT, 1'b0, 4'd10}, '{K_CARRY, 1'b0, 4'd1}, '{K_RIGHT, 1'b0, 4'd10},
      '{K_CARRY, 1'b0, 4'd1}, '{K_LEFT, 1'b0, 4'd1}, '{K_CARRY, 1'b0, 4'd1},
      '{K_CARRY, 1'b0, 4'd1}, '{K_CHOP, 1'b0, 4'd3}, '{K_CARRY, 1'b0, 4'd1},
      '{K_RIGHT, 1'b1, 4'd1}, '{K_CARRY, 1'b0, 4'd1},
      // third onion
      '{K_LEFT, 1'b0, 4'd10}, '{K_CARRY, 1'b0, 4'd1}, '{K_RIGHT, 1'b0, 4'd10},
      '{K_LEFT, 1'b0, 4'd1}, '{K_CARRY, 1'b0, 4'd1}, '{K_CHOP, 1'b1, 4'd3},
      '{K_CARRY, 1'b0, 4'd1}, '{K_RIGHT, 1'b0, 4'd1}, '{K_CARRY, 1'b0, 4'd1}};

   logic      clock_in;
   logic      reset_in;
   logic      btn_left;
   logic      btn_right;
   logic      btn_up;
   logic      btn_down;
   logic      btn_chop;
   logic      carry_switch;
   tile_x_t   player_x;
   tile_y_t   player_y;
   dir_t      facing;
   item_t     held_item;
   score_t    score;
   segments_t seg_cathodes;
   anodes_t   seg_anodes;

   view_t expect_tab [NUM_ROWS];
   view_t model;
   logic  model_carry;
   item_t model_item [GRID_ROWS][GRID_COLS];
   int    model_chops [GRID_ROWS][GRID_COLS];

   kitchen_top #(.debounce_cycles(DEBOUNCE)) u_kitchen_top (.*);

   bind kitchen_top kitchen_checker u_kitchen_checker (.clock_in(clock_in),
      .reset_in(reset_in), .player_x(player_x), .player_y(player_y),
      .seg_anodes(seg_anodes), .score(score));

   initial begin
      clock_in = 1'b0;
      forever #2 clock_in = ~clock_in;
   end

   ////////////////////
   // reference model
   ////////////////////

   // one debounced press
   function automatic void model_press(input key_t key);
      int   tx;
      int   ty;
      logic valid;
      logic supply;
      logic window;
      logic floor_tile;
      if (key < K_CHOP) begin
         model.d = dir_t'(key);
         case (key)
            K_UP:    if (model.y != 3'd0) model.y = model.y - 3'd1;
            K_RIGHT: if (model.x != 4'd12) model.x = model.x + 4'd1;
            K_DOWN:  if (model.y != 3'd7) model.y = model.y + 3'd1;
            default: if (model.x != 4'd0) model.x = model.x - 4'd1;
         endcase
      end else begin
         // faced tile
         tx = int'(model.x);
         ty = int'(model.y);
         case (model.d)
            DIR_UP:    ty = ty - 1;
            DIR_RIGHT: tx = tx + 1;
            DIR_DOWN:  ty = ty + 1;
            default:   tx = tx - 1;
         endcase
         valid      = tx >= 0 && tx < GRID_COLS && ty >= 0 && ty < GRID_ROWS;
         supply     = valid && tx == int'(SUPPLY_X) && ty == int'(SUPPLY_Y);
         window     = valid && tx == int'(WINDOW_X) && ty == int'(WINDOW_Y);
         floor_tile = valid && !supply && !window;
         if (key == K_CHOP) begin
            if (floor_tile && model_item[ty][tx] == ITEM_RAW) begin
               model_chops[ty][tx]++;
               if (model_chops[ty][tx] == int'(CHOP_PRESSES)) begin
                  model_item[ty][tx]  = ITEM_CHOPPED;
                  model_chops[ty][tx] = 0;
               end
            end
         end else begin
            model_carry = ~model_carry;
            // rise picks up into empty hands
            if (model_carry && model.h == ITEM_NONE) begin
               if (supply) begin
                  model.h = ITEM_RAW;
               end else if (floor_tile && model_item[ty][tx] != ITEM_NONE) begin
                  model.h             = model_item[ty][tx];
                  model_item[ty][tx]  = ITEM_NONE;
                  model_chops[ty][tx] = 0;
               end
            end else if (!model_carry && model.h != ITEM_NONE) begin
               // fall serves or puts down
               if (window && model.h == ITEM_CHOPPED) begin
                  model.s = model.s + 16'd1;
                  model.h = ITEM_NONE;
               end else if (floor_tile && model_item[ty][tx] == ITEM_NONE) begin
                  model_item[ty][tx]  = model.h;
                  model_chops[ty][tx] = 0;
                  model.h             = ITEM_NONE;
               end
            end
         end
      end
   endfunction

   // expected outputs after each table row
   function automatic void build_expected();
      model       = view_t'{START_X, START_Y, START_DIR, ITEM_NONE, 16'd0};
      model_carry = 1'b0;
      foreach (model_item[row, col]) begin
         model_item[row][col]  = ITEM_NONE;
         model_chops[row][col] = 0;
      end
      for (int r = 0; r < NUM_ROWS; r++) begin
         for (int n = 0; n < STIM[r].reps; n++) begin
            model_press(STIM[r].key);
         end
         expect_tab[r] = model;
      end
   endfunction

   ////////////////////
   // drive and check
   ////////////////////

   task automatic drive_slot();
      @(posedge clock_in);
      #1;
   endtask

   task automatic set_key(input key_t key, input logic level);
      case (key)
         K_UP:    btn_up = level;
         K_RIGHT: btn_right = level;
         K_DOWN:  btn_down = level;
         K_LEFT:  btn_left = level;
         K_CHOP:  btn_chop = level;
         default: carry_switch = level;
      endcase
   endtask

   // optional bounce and a hold until taken, then a button is let go
   task automatic press(input key_t key, input logic bounce);
      logic level;
      level = (key == K_CARRY) ? ~carry_switch : 1'b1;
      if (bounce) begin
         repeat (BOUNCE_CYCLES) begin
            drive_slot();
            set_key(key, 1'($urandom_range(1, 0)));
         end
      end
      drive_slot();
      set_key(key, level);
      repeat (SETTLE_CYCLES) drive_slot();
      // carry switch keeps its new position
      if (key != K_CARRY) begin
         set_key(key, 1'b0);
         repeat (SETTLE_CYCLES) drive_slot();
      end
   endtask

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic compare(input string what, input int got, input int want);
      if (got != want) begin
         fail_run($sformatf("mismatch at %0d ns: %s is %0d, expected %0d",
            $time, what, got, want));
      end
   endtask

   task automatic check_view(input string where, input view_t want);
      compare({where, " player_x"}, int'(player_x), int'(want.x));
      compare({where, " player_y"}, int'(player_y), int'(want.y));
      compare({where, " facing"}, int'(facing), int'(want.d));
      compare({where, " held_item"}, int'(held_item), int'(want.h));
      compare({where, " score"}, int'(score), int'(want.s));
   endtask

   // poll until the outputs match or the limit runs out
   task automatic wait_view(input int row);
      int waited;
      waited = 0;
      while ({player_x, player_y, facing, held_item, score} != expect_tab[row] &&
             waited < WAIT_LIMIT) begin
         drive_slot();
         waited++;
      end
      check_view($sformatf("row %0d", row), expect_tab[row]);
   endtask

   // every sample on the falling edge over sixteen scan slots
   task automatic check_display(input score_t want);
      int        lows;
      int        low_k;
      segments_t want_seg;
      low_k = 0;
      repeat (16 * SCAN_CYCLES) begin
         @(negedge clock_in);
         lows = 0;
         for (int k = 0; k < 4; k++) begin
            if (!seg_anodes[k]) begin
               lows++;
               low_k = k;
            end
         end
         compare("number of active anodes", lows, 1);
         want_seg = ~HEX_ON[want[low_k * 4 +: 4]];
         compare($sformatf("seg_cathodes on digit %0d", low_k),
            int'(seg_cathodes), int'(want_seg));
      end
   endtask

   initial begin
      void'($urandom(98177));
      reset_in     = 1'b1;
      btn_left     = 1'b0;
      btn_right    = 1'b0;
      btn_up       = 1'b0;
      btn_down     = 1'b0;
      btn_chop     = 1'b0;
      carry_switch = 1'b0;
      build_expected();
      repeat (2) drive_slot();
      reset_in = 1'b0;
      check_view("after reset", view_t'{START_X, START_Y, START_DIR, ITEM_NONE, 16'd0});
      compare("after reset seg_anodes", int'(seg_anodes), int'(4'b1110));
      for (int r = 0; r < NUM_ROWS; r++) begin
         for (int n = 0; n < STIM[r].reps; n++) begin
            press(STIM[r].key, STIM[r].bounce);
         end
         wait_view(r);
      end
      check_display(model.s);
      $display("Regression passed");
      $finish;
   end

endmodule
